// File: source/glb_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and counts of the global buffer tile chain
// include in any file that sizes ports or arrays from them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef GLB_CONSTS_SVH
`define GLB_CONSTS_SVH

// tiles in the chain
`define GLB_NUM_TILES    4

// processor side, one 64b word per bank entry
`define BANK_DATA_WIDTH  64
`define BANK_ADDR_WIDTH  8
`define TILE_SEL_WIDTH   2
// byte address = tile field, word field, 3 byte-offset bits
`define GLB_ADDR_WIDTH   (`TILE_SEL_WIDTH + `BANK_ADDR_WIDTH + 3)

// config side, byte address of 32b registers
`define CFG_ADDR_WIDTH   12
`define CFG_DATA_WIDTH   32
`define CFG_REG_COUNT    4
// tile field position in the config address
`define CFG_TILE_LSB     8

`endif

// File: source/glb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet and config request/response types of the tile chain
// shared by the RTL and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "glb_consts.svh"

package glb_pkg;

    // processor write request, moves west to east
    typedef struct packed {
        logic                            wr_en;
        logic [`BANK_DATA_WIDTH/8-1:0]   wr_strb;
        logic [`GLB_ADDR_WIDTH-1:0]      wr_addr;
        logic [`BANK_DATA_WIDTH-1:0]     wr_data;
    } wr_packet_t;

    // processor read request, moves west to east
    typedef struct packed {
        logic                            rd_en;
        logic [`GLB_ADDR_WIDTH-1:0]      rd_addr;
    } rdrq_packet_t;

    // read response, moves east to west
    typedef struct packed {
        logic [`BANK_DATA_WIDTH-1:0]     rd_data;
        logic                            rd_data_valid;
    } rdrs_packet_t;

    // full processor packet, same layout both directions
    typedef struct packed {
        wr_packet_t                      wr;
        rdrq_packet_t                    rdrq;
        rdrs_packet_t                    rdrs;
    } packet_t;

    // config request
    typedef struct packed {
        logic                            wr_en;
        logic [`CFG_ADDR_WIDTH-1:0]      wr_addr;
        logic [`CFG_DATA_WIDTH-1:0]      wr_data;
        logic                            rd_en;
        logic [`CFG_ADDR_WIDTH-1:0]      rd_addr;
    } cfg_req_t;

    // config read response
    typedef struct packed {
        logic [`CFG_DATA_WIDTH-1:0]      rd_data;
        logic                            rd_data_valid;
    } cfg_rsp_t;

endpackage

// File: source/glb_dummy_start.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// west end of the tile chain, purely combinational
// flat processor/config ports in, chain packets out and back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "glb_consts.svh"

module glb_dummy_start (
    // processor port
    input  logic                            proc_wr_en,
    input  logic [`BANK_DATA_WIDTH/8-1:0]   proc_wr_strb,
    input  logic [`GLB_ADDR_WIDTH-1:0]      proc_wr_addr,
    input  logic [`BANK_DATA_WIDTH-1:0]     proc_wr_data,
    input  logic                            proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]      proc_rd_addr,
    output logic [`BANK_DATA_WIDTH-1:0]     proc_rd_data,
    output logic                            proc_rd_data_valid,
    // config port
    input  logic                            cfg_wr_en,
    input  logic [`CFG_ADDR_WIDTH-1:0]      cfg_wr_addr,
    input  logic [`CFG_DATA_WIDTH-1:0]      cfg_wr_data,
    input  logic                            cfg_rd_en,
    input  logic [`CFG_ADDR_WIDTH-1:0]      cfg_rd_addr,
    output logic [`CFG_DATA_WIDTH-1:0]      cfg_rd_data,
    output logic                            cfg_rd_data_valid,
    // chain side
    input  glb_pkg::packet_t                proc_packet_e2w,
    input  glb_pkg::cfg_rsp_t               cfg_rsp_e2w,
    output glb_pkg::packet_t                proc_packet_w2e,
    output glb_pkg::cfg_req_t               cfg_req_w2e
);

    // processor requests into the packet
    assign proc_packet_w2e.wr.wr_en     = proc_wr_en;
    assign proc_packet_w2e.wr.wr_strb   = proc_wr_strb;
    assign proc_packet_w2e.wr.wr_addr   = proc_wr_addr;
    assign proc_packet_w2e.wr.wr_data   = proc_wr_data;
    assign proc_packet_w2e.rdrq.rd_en   = proc_rd_en;
    assign proc_packet_w2e.rdrq.rd_addr = proc_rd_addr;
    // no response starts here
    assign proc_packet_w2e.rdrs         = '0;

    // response from tile 0
    assign proc_rd_data       = proc_packet_e2w.rdrs.rd_data;
    assign proc_rd_data_valid = proc_packet_e2w.rdrs.rd_data_valid;

    // config request and response
    assign cfg_req_w2e       = '{cfg_wr_en, cfg_wr_addr, cfg_wr_data, cfg_rd_en, cfg_rd_addr};
    assign cfg_rd_data       = cfg_rsp_e2w.rd_data;
    assign cfg_rd_data_valid = cfg_rsp_e2w.rd_data_valid;

    // a read entering the chain must carry a known address,
    // otherwise no tile decodes it and the response never comes
    always_comb begin
        assert final (!(proc_rd_en === 1'b1 && $isunknown(proc_rd_addr)))
            else $error("proc read enabled with unknown address");
        assert final (!(cfg_rd_en === 1'b1 && $isunknown(cfg_rd_addr)))
            else $error("cfg read enabled with unknown address");
    end

endmodule

// File: source/glb_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one 256 x 64b SRAM bank of a tile
// byte write strobes, read data registered one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "glb_consts.svh"

module glb_bank (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wr_en,
    input  logic [`BANK_DATA_WIDTH/8-1:0]   wr_strb,
    input  logic [`BANK_ADDR_WIDTH-1:0]     wr_addr,
    input  logic [`BANK_DATA_WIDTH-1:0]     wr_data,
    input  logic                            rd_en,
    input  logic [`BANK_ADDR_WIDTH-1:0]     rd_addr,
    output logic [`BANK_DATA_WIDTH-1:0]     rd_data,
    output logic                            rd_data_valid
);

    localparam int num_words = 1 << `BANK_ADDR_WIDTH;
    localparam int num_bytes = `BANK_DATA_WIDTH / 8;

    // storage, contents undefined after reset
    logic [`BANK_DATA_WIDTH-1:0] mem [num_words];

    // write only the strobed bytes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < num_bytes; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // read data, only updated on a read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // valid follows rd_en by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_en;
        end
    end

    // a write needs a known word and strobe, else the bank is silently corrupted
    assert property (@(posedge clk) disable iff (reset) wr_en |-> !$isunknown({wr_addr, wr_strb}))
        else $error("bank write with unknown address or strobe");

endmodule

// File: source/glb_cfg_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-tile config register file, four 32b registers
// register 0 bit 0 locks processor writes to the tile bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "glb_consts.svh"

module glb_cfg_regs (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wr_en,
    input  logic                            rd_en,
    // word select, config address bits below the tile field
    input  logic [`CFG_TILE_LSB-3:0]        reg_sel,
    input  logic [`CFG_DATA_WIDTH-1:0]      wr_data,
    output logic [`CFG_DATA_WIDTH-1:0]      rd_data,
    output logic                            rd_data_valid,
    output logic                            wr_lock
);

    localparam int idx_width = $clog2(`CFG_REG_COUNT);

    logic [`CFG_DATA_WIDTH-1:0] regs [`CFG_REG_COUNT];
    logic [idx_width-1:0]       idx;
    logic                       sel_ok;

    // index into the file, upper select bits must be zero
    assign idx    = reg_sel[idx_width-1:0];
    assign sel_ok = (reg_sel < `CFG_REG_COUNT);

    // register writes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `CFG_REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en && sel_ok) begin
            regs[idx] <= wr_data;
        end
    end

    // read data, out of range reads return zero
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= sel_ok ? regs[idx] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_en;
        end
    end

    // lock bit
    assign wr_lock = regs[0][0];

    // tile decode must hand over only existing register indexes
    assert property (@(posedge clk) disable iff (reset) (wr_en || rd_en) |-> sel_ok)
        else $error("config access to missing register %0d", reg_sel);

endmodule

// File: source/glb_tile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one tile of the global buffer chain
// registers passing requests, serves its own tile field,
// merges its read responses into the westward chain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "glb_consts.svh"

module glb_tile #(
    parameter int tile_id = 0
) (
    input  logic                clk,
    input  logic                reset,
    input  glb_pkg::packet_t    proc_packet_w2e_in,
    input  glb_pkg::packet_t    proc_packet_e2w_in,
    input  glb_pkg::cfg_req_t   cfg_req_w2e_in,
    input  glb_pkg::cfg_rsp_t   cfg_rsp_e2w_in,
    output glb_pkg::packet_t    proc_packet_w2e_out,
    output glb_pkg::packet_t    proc_packet_e2w_out,
    output glb_pkg::cfg_req_t   cfg_req_w2e_out,
    output glb_pkg::cfg_rsp_t   cfg_rsp_e2w_out
);
    import glb_pkg::*;

    // proc address: tile | word | byte offset
    localparam int word_lsb  = 3;
    localparam int tile_lsb  = word_lsb + `BANK_ADDR_WIDTH;
    localparam logic [`TILE_SEL_WIDTH-1:0] tile_sel = `TILE_SEL_WIDTH'(tile_id);

    packet_t                     proc_req_q;
    cfg_req_t                    cfg_req_q;
    rdrs_packet_t                proc_rsp_q;
    cfg_rsp_t                    cfg_rsp_q;
    logic                        wr_hit;
    logic                        rd_hit;
    logic                        cfg_wr_hit;
    logic                        cfg_rd_hit;
    logic                        wr_lock;
    logic [`CFG_TILE_LSB-3:0]    reg_sel;
    logic [`BANK_DATA_WIDTH-1:0] bank_rd_data;
    logic                        bank_rd_data_valid;
    logic [`CFG_DATA_WIDTH-1:0]  cfg_rd_data;
    logic                        cfg_rd_data_valid;

    // one register stage per tile on the eastward requests
    always_ff @(posedge clk) begin
        if (reset) begin
            proc_req_q <= '0;
            cfg_req_q  <= '0;
        end else begin
            proc_req_q <= proc_packet_w2e_in;
            cfg_req_q  <= cfg_req_w2e_in;
        end
    end

    // tile field decode
    assign wr_hit = proc_req_q.wr.wr_en &&
                    (proc_req_q.wr.wr_addr[tile_lsb +: `TILE_SEL_WIDTH] == tile_sel);
    assign rd_hit = proc_req_q.rdrq.rd_en &&
                    (proc_req_q.rdrq.rd_addr[tile_lsb +: `TILE_SEL_WIDTH] == tile_sel);
    assign cfg_wr_hit = cfg_req_q.wr_en &&
                        (cfg_req_q.wr_addr[`CFG_TILE_LSB +: `TILE_SEL_WIDTH] == tile_sel);
    assign cfg_rd_hit = cfg_req_q.rd_en &&
                        (cfg_req_q.rd_addr[`CFG_TILE_LSB +: `TILE_SEL_WIDTH] == tile_sel);

    // consumed requests stop here, the rest go east
    always_comb begin
        proc_packet_w2e_out            = proc_req_q;
        proc_packet_w2e_out.wr.wr_en   = proc_req_q.wr.wr_en & ~wr_hit;
        proc_packet_w2e_out.rdrq.rd_en = proc_req_q.rdrq.rd_en & ~rd_hit;
        cfg_req_w2e_out                = cfg_req_q;
        cfg_req_w2e_out.wr_en          = cfg_req_q.wr_en & ~cfg_wr_hit;
        cfg_req_w2e_out.rd_en          = cfg_req_q.rd_en & ~cfg_rd_hit;
    end

    // locked writes are dropped, still consumed above
    glb_bank bank (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_hit && !wr_lock),
        .wr_strb       (proc_req_q.wr.wr_strb),
        .wr_addr       (proc_req_q.wr.wr_addr[word_lsb +: `BANK_ADDR_WIDTH]),
        .wr_data       (proc_req_q.wr.wr_data),
        .rd_en         (rd_hit),
        .rd_addr       (proc_req_q.rdrq.rd_addr[word_lsb +: `BANK_ADDR_WIDTH]),
        .rd_data       (bank_rd_data),
        .rd_data_valid (bank_rd_data_valid)
    );

    // register index from bits [7:2], write wins the shared select
    assign reg_sel = cfg_wr_hit ? cfg_req_q.wr_addr[`CFG_TILE_LSB-1:2]
                                : cfg_req_q.rd_addr[`CFG_TILE_LSB-1:2];

    glb_cfg_regs cfg_regs (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (cfg_wr_hit),
        .rd_en         (cfg_rd_hit),
        .reg_sel       (reg_sel),
        .wr_data       (cfg_req_q.wr_data),
        .rd_data       (cfg_rd_data),
        .rd_data_valid (cfg_rd_data_valid),
        .wr_lock       (wr_lock)
    );

    // westward merge, local response takes the slot
    always_ff @(posedge clk) begin
        if (reset) begin
            proc_rsp_q <= '0;
            cfg_rsp_q  <= '0;
        end else begin
            proc_rsp_q <= bank_rd_data_valid ? '{bank_rd_data, 1'b1}
                                             : proc_packet_e2w_in.rdrs;
            cfg_rsp_q  <= cfg_rd_data_valid ? '{cfg_rd_data, 1'b1} : cfg_rsp_e2w_in;
        end
    end

    // only the response field travels west
    always_comb begin
        proc_packet_e2w_out      = '0;
        proc_packet_e2w_out.rdrs = proc_rsp_q;
    end
    assign cfg_rsp_e2w_out = cfg_rsp_q;

    // one read in flight per chain, so responses never meet
    assert property (@(posedge clk) disable iff (reset)
        !(bank_rd_data_valid && proc_packet_e2w_in.rdrs.rd_data_valid))
        else $error("tile %0d proc response collision", tile_id);
    assert property (@(posedge clk) disable iff (reset)
        !(cfg_rd_data_valid && cfg_rsp_e2w_in.rd_data_valid))
        else $error("tile %0d cfg response collision", tile_id);
    // shared register select cannot serve a write and a read together
    assert property (@(posedge clk) disable iff (reset) !(cfg_wr_hit && cfg_rd_hit))
        else $error("tile %0d cfg write and read in one cycle", tile_id);

endmodule

// File: source/global_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// global buffer top, dummy start plus a chain of tiles
// flat processor and config ports enter at the west end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "glb_consts.svh"

module global_buffer (
    input  logic                            clk,
    input  logic                            reset,
    // processor port
    input  logic                            proc_wr_en,
    input  logic [`BANK_DATA_WIDTH/8-1:0]   proc_wr_strb,
    input  logic [`GLB_ADDR_WIDTH-1:0]      proc_wr_addr,
    input  logic [`BANK_DATA_WIDTH-1:0]     proc_wr_data,
    input  logic                            proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]      proc_rd_addr,
    output logic [`BANK_DATA_WIDTH-1:0]     proc_rd_data,
    output logic                            proc_rd_data_valid,
    // config port
    input  logic                            cfg_wr_en,
    input  logic [`CFG_ADDR_WIDTH-1:0]      cfg_wr_addr,
    input  logic [`CFG_DATA_WIDTH-1:0]      cfg_wr_data,
    input  logic                            cfg_rd_en,
    input  logic [`CFG_ADDR_WIDTH-1:0]      cfg_rd_addr,
    output logic [`CFG_DATA_WIDTH-1:0]      cfg_rd_data,
    output logic                            cfg_rd_data_valid
);
    import glb_pkg::*;

    // link i sits west of tile i, last link is the east end
    packet_t  proc_w2e [`GLB_NUM_TILES+1];
    packet_t  proc_e2w [`GLB_NUM_TILES+1];
    cfg_req_t cfg_w2e  [`GLB_NUM_TILES+1];
    cfg_rsp_t cfg_e2w  [`GLB_NUM_TILES+1];

    glb_dummy_start dummy_start (
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .cfg_wr_en          (cfg_wr_en),
        .cfg_wr_addr        (cfg_wr_addr),
        .cfg_wr_data        (cfg_wr_data),
        .cfg_rd_en          (cfg_rd_en),
        .cfg_rd_addr        (cfg_rd_addr),
        .cfg_rd_data        (cfg_rd_data),
        .cfg_rd_data_valid  (cfg_rd_data_valid),
        .proc_packet_e2w    (proc_e2w[0]),
        .cfg_rsp_e2w        (cfg_e2w[0]),
        .proc_packet_w2e    (proc_w2e[0]),
        .cfg_req_w2e        (cfg_w2e[0])
    );

    // tile chain
    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : g_tile
        glb_tile #(.tile_id(i)) tile (
            .clk                 (clk),
            .reset               (reset),
            .proc_packet_w2e_in  (proc_w2e[i]),
            .proc_packet_e2w_in  (proc_e2w[i+1]),
            .cfg_req_w2e_in      (cfg_w2e[i]),
            .cfg_rsp_e2w_in      (cfg_e2w[i+1]),
            .proc_packet_w2e_out (proc_w2e[i+1]),
            .proc_packet_e2w_out (proc_e2w[i]),
            .cfg_req_w2e_out     (cfg_w2e[i+1]),
            .cfg_rsp_e2w_out     (cfg_e2w[i])
        );
    end

    // nothing returns from east of the last tile
    assign proc_e2w[`GLB_NUM_TILES] = '0;
    assign cfg_e2w[`GLB_NUM_TILES]  = '0;

endmodule

// File: testbench/global_buffer_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the global buffer tile chain
// seeded random processor and config traffic, checked
// against bank and register models kept here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "glb_consts.svh"

module global_buffer_tb;

    localparam int num_words    = 1 << `BANK_ADDR_WIDTH;
    localparam int tile_lsb     = 3 + `BANK_ADDR_WIDTH;
    // worst case response time, farthest tile and back
    localparam int read_bound   = 2 * `GLB_NUM_TILES + 4;
    localparam int n_init_reads = 64;
    localparam int n_strb       = 48;
    localparam int n_raw        = 24;
    localparam int n_cfg        = 48;
    localparam int n_lock       = 32;
    localparam int n_reads      = `GLB_NUM_TILES * `CFG_REG_COUNT + n_init_reads + n_strb
                                  + n_raw + n_cfg + 2 * n_lock;
    localparam int n_writes     = `GLB_NUM_TILES * num_words + n_strb + n_raw + n_cfg
                                  + 2 * n_lock + `GLB_NUM_TILES + 2;
    localparam int timeout_cycles = 4 + n_writes + n_reads * (read_bound + 2) + 200;

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          proc_wr_en;
    logic [`BANK_DATA_WIDTH/8-1:0] proc_wr_strb;
    logic [`GLB_ADDR_WIDTH-1:0]    proc_wr_addr;
    logic [`BANK_DATA_WIDTH-1:0]   proc_wr_data;
    logic                          proc_rd_en;
    logic [`GLB_ADDR_WIDTH-1:0]    proc_rd_addr;
    logic [`BANK_DATA_WIDTH-1:0]   proc_rd_data;
    logic                          proc_rd_data_valid;
    logic                          cfg_wr_en;
    logic [`CFG_ADDR_WIDTH-1:0]    cfg_wr_addr;
    logic [`CFG_DATA_WIDTH-1:0]    cfg_wr_data;
    logic                          cfg_rd_en;
    logic [`CFG_ADDR_WIDTH-1:0]    cfg_rd_addr;
    logic [`CFG_DATA_WIDTH-1:0]    cfg_rd_data;
    logic                          cfg_rd_data_valid;

    // reference models
    logic [`BANK_DATA_WIDTH-1:0] mem_model [`GLB_NUM_TILES][num_words];
    logic [`CFG_DATA_WIDTH-1:0]  cfg_model [`GLB_NUM_TILES][`CFG_REG_COUNT];
    integer seed;
    int     cycle_count = 0;

    global_buffer dut0 (.*);

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("ERROR at %0t: %s", $time, reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_proc_rd(input logic [`BANK_DATA_WIDTH-1:0] expected);
        if (proc_rd_data !== expected) begin
            $display("MISMATCH at %0t: proc_rd_data expected %h actual %h",
                     $time, expected, proc_rd_data);
            abort_run("processor read data differs from model");
        end
    endtask

    task automatic check_cfg_rd(input logic [`CFG_DATA_WIDTH-1:0] expected);
        if (cfg_rd_data !== expected) begin
            $display("MISMATCH at %0t: cfg_rd_data expected %h actual %h",
                     $time, expected, cfg_rd_data);
            abort_run("config read data differs from model");
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, expected, actual);
            abort_run("strobe level differs from expected");
        end
    endtask

    // write issued on the next edge, model follows the lock bit
    task automatic proc_write(input logic [`GLB_ADDR_WIDTH-1:0] addr,
                              input logic [`BANK_DATA_WIDTH/8-1:0] strb,
                              input logic [`BANK_DATA_WIDTH-1:0] data);
        int t;
        int w;
        t = addr[tile_lsb +: `TILE_SEL_WIDTH];
        w = addr[3 +: `BANK_ADDR_WIDTH];
        @(posedge clk);
        proc_rd_en   <= 1'b0;
        cfg_wr_en    <= 1'b0;
        cfg_rd_en    <= 1'b0;
        proc_wr_en   <= 1'b1;
        proc_wr_strb <= strb;
        proc_wr_addr <= addr;
        proc_wr_data <= data;
        if (!cfg_model[t][0][0]) begin
            for (int b = 0; b < `BANK_DATA_WIDTH / 8; b++) begin
                if (strb[b]) begin
                    mem_model[t][w][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
    endtask

    // one read in flight, wait for the valid pulse
    task automatic proc_read(input logic [`GLB_ADDR_WIDTH-1:0] addr);
        logic [`BANK_DATA_WIDTH-1:0] expected;
        int waited;
        expected = mem_model[addr[tile_lsb +: `TILE_SEL_WIDTH]][addr[3 +: `BANK_ADDR_WIDTH]];
        waited   = 0;
        @(posedge clk);
        proc_wr_en   <= 1'b0;
        cfg_wr_en    <= 1'b0;
        proc_rd_en   <= 1'b1;
        proc_rd_addr <= addr;
        @(posedge clk);
        proc_rd_en <= 1'b0;
        while (!proc_rd_data_valid && waited < read_bound) begin
            @(posedge clk);
            waited++;
        end
        if (!proc_rd_data_valid) abort_run("read response never arrived");
        else check_proc_rd(expected);
    endtask

    task automatic cfg_write(input int t, input int r, input logic [`CFG_DATA_WIDTH-1:0] data);
        @(posedge clk);
        proc_wr_en  <= 1'b0;
        proc_rd_en  <= 1'b0;
        cfg_rd_en   <= 1'b0;
        cfg_wr_en   <= 1'b1;
        cfg_wr_addr <= (t << `CFG_TILE_LSB) | (r << 2);
        cfg_wr_data <= data;
        cfg_model[t][r] = data;
    endtask

    task automatic cfg_read(input int t, input int r);
        int waited;
        waited = 0;
        @(posedge clk);
        proc_wr_en  <= 1'b0;
        cfg_wr_en   <= 1'b0;
        cfg_rd_en   <= 1'b1;
        cfg_rd_addr <= (t << `CFG_TILE_LSB) | (r << 2);
        @(posedge clk);
        cfg_rd_en <= 1'b0;
        while (!cfg_rd_data_valid && waited < read_bound) begin
            @(posedge clk);
            waited++;
        end
        if (!cfg_rd_data_valid) abort_run("read response never arrived");
        else check_cfg_rd(cfg_model[t][r]);
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            abort_run("timeout, tests did not finish within the cycle limit");
        end
    end

    initial begin
        logic [`GLB_ADDR_WIDTH-1:0] addr;
        int lock_tile;
        seed         = 32'hb8abf87a;
        reset        = 1'b1;
        proc_wr_en   = 1'b0;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en   = 1'b0;
        proc_rd_addr = '0;
        cfg_wr_en    = 1'b0;
        cfg_wr_addr  = '0;
        cfg_wr_data  = '0;
        cfg_rd_en    = 1'b0;
        cfg_rd_addr  = '0;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int r = 0; r < `CFG_REG_COUNT; r++) begin
                cfg_model[t][r] = '0;
            end
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // reset state, no strobes and cleared registers
        @(posedge clk);
        check_bit("proc_rd_data_valid", proc_rd_data_valid, 1'b0);
        check_bit("cfg_rd_data_valid", cfg_rd_data_valid, 1'b0);
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int r = 0; r < `CFG_REG_COUNT; r++) begin
                cfg_read(t, r);
            end
        end

        // fill every bank back to back
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int w = 0; w < num_words; w++) begin
                addr = {t[`TILE_SEL_WIDTH-1:0], w[`BANK_ADDR_WIDTH-1:0], 3'b000};
                proc_write(addr, '1, {$random(seed), $random(seed)});
            end
        end
        for (int i = 0; i < n_init_reads; i++) begin
            proc_read($random(seed));
        end

        // partial strobes, one idle cycle before the readback
        for (int i = 0; i < n_strb; i++) begin
            addr = $random(seed);
            proc_write(addr, $random(seed), {$random(seed), $random(seed)});
            @(posedge clk);
            proc_wr_en <= 1'b0;
            proc_read(addr);
        end

        // read right behind the write, chain keeps order
        for (int i = 0; i < n_raw; i++) begin
            addr = $random(seed);
            proc_write(addr, '1, {$random(seed), $random(seed)});
            proc_read(addr);
        end

        // random config traffic over all tiles and registers
        for (int i = 0; i < n_cfg; i++) begin
            if ($random(seed) & 1) begin
                cfg_write($unsigned($random(seed)) % `GLB_NUM_TILES,
                          $unsigned($random(seed)) % `CFG_REG_COUNT, $random(seed));
            end else begin
                cfg_read($unsigned($random(seed)) % `GLB_NUM_TILES,
                         $unsigned($random(seed)) % `CFG_REG_COUNT);
            end
        end

        // lock one tile, others stay writable
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            cfg_write(t, 0, '0);
        end
        lock_tile = $unsigned($random(seed)) % `GLB_NUM_TILES;
        cfg_write(lock_tile, 0, 32'h1);
        cfg_read(lock_tile, 0);
        for (int i = 0; i < n_lock; i++) begin
            addr = $random(seed);
            if (i % 2 == 0) begin
                addr[tile_lsb +: `TILE_SEL_WIDTH] = lock_tile;
            end
            proc_write(addr, '1, {$random(seed), $random(seed)});
            proc_read(addr);
        end
        // unlocked again, writes land
        cfg_write(lock_tile, 0, 32'h0);
        cfg_read(lock_tile, 0);
        for (int i = 0; i < n_lock; i++) begin
            addr = $random(seed);
            addr[tile_lsb +: `TILE_SEL_WIDTH] = lock_tile;
            proc_write(addr, '1, {$random(seed), $random(seed)});
            proc_read(addr);
        end

        @(posedge clk);
        proc_wr_en <= 1'b0;
        cfg_wr_en  <= 1'b0;
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/glb_pkg.sv
source/glb_dummy_start.sv
source/glb_bank.sv
source/glb_cfg_regs.sv
source/glb_tile.sv
source/global_buffer.sv
testbench/global_buffer_tb.sv
